// ==== rtl/fetch_pkg.sv ====
package fetch_pkg;

  ////////////////////
  // widths
  ////////////////////
  localparam int PC_W   = 64;  // address width
  localparam int INST_W = 32;  // one instruction
  localparam int LINE_W = 64;  // one memory line, two instructions

  ////////////////////
  // types
  ////////////////////
  typedef logic [PC_W-1:0]   pc_t;         // instruction address
  typedef logic [INST_W-1:0] inst_t;       // fetched instruction word
  typedef logic [LINE_W-1:0] imem_line_t;  // lower word at pc[2]==0, upper at pc[2]==1

  // 2-bit saturating counter, counts up on taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11
  } bp_state_t;

  // pc after reset
  localparam pc_t reset_pc = 64'h0;

  ////////////////////
  // helpers
  ////////////////////

  // both upper states predict taken
  function automatic logic bp_predict_taken(input bp_state_t state);
    logic taken;
    taken = (state == weak_taken) || (state == strong_taken);
    return taken;
  endfunction

endpackage

// ==== rtl/imem.sv ====
`timescale 1ns/1ps

module imem import fetch_pkg::*; #(
  parameter int IMEM_LINES = 64  // number of 64-bit lines
) (
  input  logic       clock,
  // load port from the testbench
  input  logic       imem_write_en,
  input  pc_t        imem_write_addr,  // byte address, bits [2:0] ignored
  input  imem_line_t imem_write_data,
  // fetch read port
  input  pc_t        proc2imem_addr,
  output imem_line_t imem2proc_data,
  output logic       imem_valid        // low past the last line
);

  localparam int IDX_W = (IMEM_LINES > 1) ? $clog2(IMEM_LINES) : 1;
  localparam int NUM_W = PC_W - 3;  // line number width
  localparam logic [NUM_W-1:0] LINE_LIMIT = NUM_W'(IMEM_LINES);

  imem_line_t mem [IMEM_LINES];  // line storage

  logic [NUM_W-1:0] rd_line;  // line number of the fetch address
  logic [NUM_W-1:0] wr_line;  // line number of the load address
  logic             wr_ok;

  assign rd_line = proc2imem_addr[PC_W-1:3];
  assign wr_line = imem_write_addr[PC_W-1:3];
  assign wr_ok   = wr_line < LINE_LIMIT;  // out-of-range loads are dropped

  ////////////////////
  // write on clock
  ////////////////////
  always_ff @(posedge clock) begin
    if (imem_write_en && wr_ok) begin
      mem[wr_line[IDX_W-1:0]] <= imem_write_data;
    end
  end

  ////////////////////
  // combinational read
  ////////////////////
  assign imem_valid     = rd_line < LINE_LIMIT;  // stalls fetch past the array
  assign imem2proc_data = imem_valid ? mem[rd_line[IDX_W-1:0]] : '0;

endmodule

// ==== rtl/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; #(
  parameter int BTB_ENTRIES = 8  // power of two
) (
  input  logic clock,
  input  logic reset,
  // lookup on the fetch pc
  input  pc_t  if_pc,
  output pc_t  bp_npc,
  output logic bp_npc_valid,
  // training from retirement
  input  logic co_ret_branch_valid,   // one-cycle pulse
  input  pc_t  co_ret_branch_pc,
  input  logic co_ret_branch_taken,
  input  pc_t  co_ret_target_pc
);

  localparam int INDEX_W = $clog2(BTB_ENTRIES);
  localparam int TAG_W   = PC_W - 2 - INDEX_W;  // pc bits above the index

  logic             entry_valid  [BTB_ENTRIES];
  logic [TAG_W-1:0] entry_tag    [BTB_ENTRIES];
  pc_t              entry_target [BTB_ENTRIES];
  bp_state_t        entry_state  [BTB_ENTRIES];

  logic [INDEX_W-1:0] rd_index;
  logic [TAG_W-1:0]   rd_tag;
  logic               rd_hit;
  logic [INDEX_W-1:0] wr_index;
  logic [TAG_W-1:0]   wr_tag;
  logic               wr_hit;

  // saturating steps of the counter
  function automatic bp_state_t step_up(input bp_state_t s);
    case (s)
      strong_not_taken: return weak_not_taken;
      weak_not_taken:   return weak_taken;
      default:          return strong_taken;
    endcase
  endfunction

  function automatic bp_state_t step_down(input bp_state_t s);
    case (s)
      strong_taken: return weak_taken;
      weak_taken:   return weak_not_taken;
      default:      return strong_not_taken;
    endcase
  endfunction

  ////////////////////
  // lookup
  ////////////////////
  assign rd_index = if_pc[2 +: INDEX_W];
  assign rd_tag   = if_pc[PC_W-1 -: TAG_W];
  assign rd_hit   = entry_valid[rd_index] && (entry_tag[rd_index] == rd_tag);

  assign bp_npc       = entry_target[rd_index];
  assign bp_npc_valid = rd_hit && bp_predict_taken(entry_state[rd_index]);

  ////////////////////
  // update
  ////////////////////
  assign wr_index = co_ret_branch_pc[2 +: INDEX_W];
  assign wr_tag   = co_ret_branch_pc[PC_W-1 -: TAG_W];
  assign wr_hit   = entry_valid[wr_index] && (entry_tag[wr_index] == wr_tag);

  // valid bits and counters
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        entry_valid[i] <= 1'b0;
        entry_state[i] <= strong_not_taken;
      end
    end else if (co_ret_branch_valid) begin
      if (co_ret_branch_taken) begin
        entry_valid[wr_index] <= 1'b1;
        // fresh allocation starts one step into taken
        entry_state[wr_index] <= wr_hit ? step_up(entry_state[wr_index]) : weak_taken;
      end else if (wr_hit) begin
        entry_state[wr_index] <= step_down(entry_state[wr_index]);  // miss leaves entry alone
      end
    end
  end

  // tags and targets, written only by taken branches
  always_ff @(posedge clock) begin
    if (co_ret_branch_valid && co_ret_branch_taken) begin
      entry_tag[wr_index]    <= wr_tag;
      entry_target[wr_index] <= co_ret_target_pc;
    end
  end

endmodule

// ==== rtl/if_stage.sv ====
`timescale 1ns/1ps

module if_stage import fetch_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  // redirect from retirement
  input  logic       co_ret_take_branch,  // one-cycle pulse, beats everything
  input  pc_t        co_ret_target_pc,
  // instruction memory
  input  imem_line_t imem2proc_data,
  input  logic       imem_valid,
  // fetch buffer
  input  logic       buffer_space,
  // predictor
  input  pc_t        bp_npc,
  input  logic       bp_npc_valid,
  // outputs
  output pc_t        proc2imem_addr,
  output pc_t        if_pc,
  output pc_t        if_npc,              // where fetch goes next
  output inst_t      if_inst,
  output logic       if_valid_inst        // accept, buffer takes it as is
);

  pc_t  pc_reg;     // pc being fetched
  pc_t  pc_plus_4;
  pc_t  next_pc;    // sequential or predicted
  logic accept;

  ////////////////////
  // next pc
  ////////////////////
  assign pc_plus_4 = pc_reg + 64'd4;
  assign next_pc   = bp_npc_valid ? bp_npc : pc_plus_4;  // prediction replaces pc+4

  // memory answers, buffer has room and no redirect this cycle
  assign accept = imem_valid && buffer_space && !co_ret_take_branch;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_reg <= reset_pc;
    end else if (co_ret_take_branch) begin
      pc_reg <= co_ret_target_pc;  // redirect wins over accept
    end else if (accept) begin
      pc_reg <= next_pc;
    end
    // otherwise hold, stalled on memory range or full buffer
  end

  ////////////////////
  // outputs
  ////////////////////
  assign proc2imem_addr = pc_reg;
  assign if_pc          = pc_reg;
  assign if_npc         = next_pc;

  // 64-bit line, pc[2] picks the half
  assign if_inst = pc_reg[2] ? imem2proc_data[63:32] : imem2proc_data[31:0];

  assign if_valid_inst = accept;

endmodule

// ==== rtl/fetch_buffer.sv ====
`timescale 1ns/1ps

module fetch_buffer import fetch_pkg::*; #(
  parameter int FB_DEPTH = 4  // entries
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  flush,           // redirect, drops all entries
  // from fetch
  input  logic  if_valid_inst,
  input  pc_t   if_pc,
  input  pc_t   if_npc,
  input  inst_t if_inst,
  output logic  buffer_space,    // not full
  // toward dispatch
  input  logic  dispatch_ready,
  output logic  dispatch_valid,
  output inst_t dispatch_inst,
  output pc_t   dispatch_pc,
  output pc_t   dispatch_npc
);

  localparam int PTR_W = (FB_DEPTH > 1) ? $clog2(FB_DEPTH) : 1;
  localparam int CNT_W = $clog2(FB_DEPTH + 1);

  inst_t inst_q [FB_DEPTH];  // payload, no reset
  pc_t   pc_q   [FB_DEPTH];
  pc_t   npc_q  [FB_DEPTH];

  logic [PTR_W-1:0] head;   // oldest entry
  logic [PTR_W-1:0] tail;   // next free slot
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wrap for any depth, not only powers of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(FB_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign push = if_valid_inst;                   // already gated on space
  assign pop  = dispatch_valid && dispatch_ready;

  ////////////////////
  // pointers and count
  ////////////////////
  always_ff @(posedge clock) begin
    if (reset || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= ptr_next(tail);
      if (pop)  head <= ptr_next(head);
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // both or neither
      endcase
    end
  end

  // storage
  always_ff @(posedge clock) begin
    if (push) begin
      inst_q[tail] <= if_inst;
      pc_q[tail]   <= if_pc;
      npc_q[tail]  <= if_npc;
    end
  end

  ////////////////////
  // outputs
  ////////////////////
  assign buffer_space   = count != CNT_W'(FB_DEPTH);
  assign dispatch_valid = count != '0;
  assign dispatch_inst  = inst_q[head];
  assign dispatch_pc    = pc_q[head];
  assign dispatch_npc   = npc_q[head];

endmodule

// ==== rtl/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; #(
  parameter int IMEM_LINES  = 64,
  parameter int BTB_ENTRIES = 8,
  parameter int FB_DEPTH    = 4
) (
  input  logic       clock,
  input  logic       reset,
  // program load
  input  logic       imem_write_en,
  input  pc_t        imem_write_addr,
  input  imem_line_t imem_write_data,
  // retirement, redirect and predictor training
  input  logic       co_ret_take_branch,
  input  pc_t        co_ret_target_pc,     // shared by redirect and update
  input  logic       co_ret_branch_valid,
  input  pc_t        co_ret_branch_pc,
  input  logic       co_ret_branch_taken,
  // dispatch
  input  logic       dispatch_ready,
  output logic       dispatch_valid,
  output inst_t      dispatch_inst,
  output pc_t        dispatch_pc,
  output pc_t        dispatch_npc
);

  pc_t        proc2imem_addr;
  imem_line_t imem2proc_data;
  logic       imem_valid;
  pc_t        if_pc;
  pc_t        bp_npc;
  logic       bp_npc_valid;
  logic       buffer_space;
  logic       if_valid_inst;
  inst_t      if_inst;
  pc_t        if_npc;

  imem #(.IMEM_LINES(IMEM_LINES)) u_imem (
    .clock, .imem_write_en, .imem_write_addr, .imem_write_data,
    .proc2imem_addr, .imem2proc_data, .imem_valid
  );

  branch_predictor #(.BTB_ENTRIES(BTB_ENTRIES)) u_bp (
    .clock, .reset, .if_pc, .bp_npc, .bp_npc_valid,
    .co_ret_branch_valid, .co_ret_branch_pc, .co_ret_branch_taken, .co_ret_target_pc
  );

  if_stage u_if (
    .clock, .reset, .co_ret_take_branch, .co_ret_target_pc,
    .imem2proc_data, .imem_valid, .buffer_space, .bp_npc, .bp_npc_valid,
    .proc2imem_addr, .if_pc, .if_npc, .if_inst, .if_valid_inst
  );

  // redirect flushes whatever was fetched down the old path
  fetch_buffer #(.FB_DEPTH(FB_DEPTH)) u_fb (
    .clock, .reset, .flush(co_ret_take_branch),
    .if_valid_inst, .if_pc, .if_npc, .if_inst, .buffer_space,
    .dispatch_ready, .dispatch_valid, .dispatch_inst, .dispatch_pc, .dispatch_npc
  );

endmodule

// ==== bench/fetch_model.svh ====
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// expected behavior of the front end, included inside fetch_tb
imem_line_t image         [IMEM_LINES];   // copy of the loaded program
logic       mirror_valid  [BTB_ENTRIES];
pc_t        mirror_tag    [BTB_ENTRIES];  // pc with offset and index shifted out
pc_t        mirror_target [BTB_ENTRIES];
bp_state_t  mirror_state  [BTB_ENTRIES];

// fill pattern, odd multiplier keeps every address distinct
function automatic inst_t image_word(input pc_t pc);
  return (pc[31:0] * 32'h9e37_79b1) ^ pc[63:32] ^ 32'h5a0f_c33c;
endfunction

function automatic logic in_image(input pc_t pc);
  return (pc >> 3) < IMEM_LINES;
endfunction

function automatic inst_t expected_inst(input pc_t pc);
  imem_line_t line;
  line = image[int'(pc >> 3)];
  return pc[2] ? line[63:32] : line[31:0];  // bit 2 picks the upper word
endfunction

function automatic int btb_index(input pc_t pc);
  return int'((pc >> 2) % BTB_ENTRIES);
endfunction

function automatic pc_t btb_tag(input pc_t pc);
  return pc >> (2 + $clog2(BTB_ENTRIES));
endfunction

// target on a hit in a taken state, next word otherwise
function automatic pc_t expected_npc(input pc_t pc);
  int i;
  i = btb_index(pc);
  if (mirror_valid[i] && mirror_tag[i] == btb_tag(pc) &&
      (mirror_state[i] == weak_taken || mirror_state[i] == strong_taken)) begin
    return mirror_target[i];
  end
  return pc + 64'd4;
endfunction

task automatic clear_mirror();
  for (int i = 0; i < BTB_ENTRIES; i++) begin
    mirror_valid[i] = 1'b0;
    mirror_state[i] = strong_not_taken;
  end
endtask

// retired branch: taken allocates or counts up, not taken counts down on a hit
task automatic train_mirror(input pc_t pc, input logic taken, input pc_t target);
  int   i;
  logic hit;
  i   = btb_index(pc);
  hit = mirror_valid[i] && mirror_tag[i] == btb_tag(pc);
  if (taken) begin
    if (!hit) mirror_state[i] = weak_taken;  // fresh entry
    else if (mirror_state[i] != strong_taken) mirror_state[i] = bp_state_t'(mirror_state[i] + 1);
    mirror_valid[i]  = 1'b1;
    mirror_tag[i]    = btb_tag(pc);
    mirror_target[i] = target;
  end else if (hit && mirror_state[i] != strong_not_taken) begin
    mirror_state[i] = bp_state_t'(mirror_state[i] - 1);
  end
endtask

`endif

// ==== bench/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

  localparam int  IMEM_LINES  = 64;
  localparam int  BTB_ENTRIES = 8;
  localparam int  FB_DEPTH    = 4;
  localparam pc_t STALL_PC    = pc_t'(IMEM_LINES * 8);        // first line past memory
  localparam pc_t TAIL_PC     = pc_t'((IMEM_LINES - 2) * 8);  // last two lines
  localparam pc_t BRANCH_PC   = 64'h40;                       // trained branch
  localparam pc_t TARGET_PC   = 64'h100;
  localparam pc_t LOOP_PC     = 64'h30;                       // restart below the branch
  localparam int  N_SEQ = 16, N_RAND = 40, N_REDIR = 8, N_PRED = 12, N_TAIL = 4, N_BACK = 4;
  localparam int  N_TOTAL = N_SEQ + N_RAND + N_REDIR + 3 * N_PRED + N_TAIL + N_BACK;
  localparam int  WATCHDOG_CYCLES = 40 * N_TOTAL + 200;

  logic clock, reset, imem_write_en, co_ret_take_branch, co_ret_branch_valid;
  logic co_ret_branch_taken, dispatch_ready, dispatch_valid;
  pc_t  imem_write_addr, co_ret_target_pc, co_ret_branch_pc, dispatch_pc, dispatch_npc;
  imem_line_t imem_write_data;
  inst_t dispatch_inst;

  integer seed = 32'h01f219b3;
  int     ready_mode;  // 0 random, 1 high, 2 low
  int     transfers;
  pc_t    exp_pc;      // pc of the next transfer
  pc_t    probe_npc;   // npc seen at BRANCH_PC

  `include "fetch_model.svh"

  fetch_top #(.IMEM_LINES(IMEM_LINES), .BTB_ENTRIES(BTB_ENTRIES), .FB_DEPTH(FB_DEPTH)) DUT (
    .clock, .reset, .imem_write_en, .imem_write_addr, .imem_write_data,
    .co_ret_take_branch, .co_ret_target_pc, .co_ret_branch_valid, .co_ret_branch_pc,
    .co_ret_branch_taken, .dispatch_ready, .dispatch_valid, .dispatch_inst,
    .dispatch_pc, .dispatch_npc
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic compare_pc(input string what, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_inst(input string what, input inst_t got, input inst_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  ////////////////////
  // checker
  ////////////////////
  always @(posedge clock) begin
    pc_t npc;
    if (reset) begin
      clear_mirror();
      exp_pc = reset_pc;
    end else begin
      if (dispatch_valid && dispatch_ready) begin  // output is from before any flush
        if (!in_image(exp_pc)) begin
          fail_run($sformatf("transfer at pc %h after fetch ran off the end of memory",
                             dispatch_pc));
        end
        npc = expected_npc(exp_pc);
        compare_pc("dispatch_pc", dispatch_pc, exp_pc);
        compare_inst("dispatch_inst", dispatch_inst, expected_inst(exp_pc));
        compare_pc("dispatch_npc", dispatch_npc, npc);
        if (dispatch_pc == BRANCH_PC) probe_npc = dispatch_npc;
        exp_pc    = npc;
        transfers++;
      end
      if (co_ret_take_branch) exp_pc = co_ret_target_pc;  // queued entries are gone
      if (co_ret_branch_valid) begin
        train_mirror(co_ret_branch_pc, co_ret_branch_taken, co_ret_target_pc);
      end
    end
  end

  always @(negedge clock) begin
    logic [31:0] rnd;
    rnd = $random(seed);
    case (ready_mode)
      1:       dispatch_ready = 1'b1;
      2:       dispatch_ready = 1'b0;
      default: dispatch_ready = rnd[0];
    endcase
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    fail_run($sformatf("timeout, run not done after %0d cycles", WATCHDOG_CYCLES));
  end

  ////////////////////
  // stimulus helpers
  ////////////////////
  task automatic set_ready(input int mode);
    @(posedge clock);  // clear of the negedge driver
    ready_mode = mode;
  endtask

  task automatic wait_transfers(input int n);
    int target;
    target = transfers + n;
    wait (transfers >= target);
  endtask

  task automatic pulse_redirect(input pc_t target);
    @(negedge clock);
    co_ret_take_branch = 1'b1;
    co_ret_target_pc   = target;
    @(negedge clock);
    co_ret_take_branch = 1'b0;
  endtask

  task automatic retire_branch(input pc_t pc, input logic taken, input pc_t target);
    @(negedge clock);
    co_ret_branch_valid = 1'b1;
    co_ret_branch_pc    = pc;
    co_ret_branch_taken = taken;
    co_ret_target_pc    = target;
    @(negedge clock);
    co_ret_branch_valid = 1'b0;
  endtask

  task automatic load_program();
    for (int i = 0; i < IMEM_LINES; i++) begin
      @(negedge clock);
      image[i]        = {image_word(pc_t'(i * 8 + 4)), image_word(pc_t'(i * 8))};
      imem_write_en   = 1'b1;
      imem_write_addr = pc_t'(i * 8);
      imem_write_data = image[i];
    end
    @(negedge clock);
    imem_write_en = 1'b0;
  endtask

  // restart below the branch, then see where fetch went after it
  task automatic run_loop(input pc_t npc_at_branch);
    probe_npc = '0;
    pulse_redirect(LOOP_PC);
    wait_transfers(N_PRED);
    compare_pc("npc at trained branch", probe_npc, npc_at_branch);
  endtask

  ////////////////////
  // tests
  ////////////////////
  initial begin
    int parked;
    {reset, ready_mode} = {1'b1, 32'd2};
    {imem_write_en, co_ret_take_branch, co_ret_branch_valid, co_ret_branch_taken} = '0;
    {imem_write_addr, co_ret_target_pc, co_ret_branch_pc, imem_write_data} = '0;
    {dispatch_ready, transfers, probe_npc} = '0;
    clear_mirror();
    // lines are written ahead of fetch while dispatch holds the buffer full
    fork
      load_program();
      begin
        repeat (3) @(posedge clock);
        @(negedge clock);
        compare_flag("dispatch_valid after reset", dispatch_valid, 1'b0);
        reset = 1'b0;
      end
    join
    set_ready(1);  // first transfer from reset_pc, then a sequential run
    wait_transfers(N_SEQ);
    set_ready(0);  // random back-pressure
    wait_transfers(N_RAND);
    set_ready(2);  // fill the buffer, then redirect over it
    repeat (8) @(negedge clock);
    set_ready(1);
    pulse_redirect(64'h80);
    set_ready(0);
    wait_transfers(N_REDIR);
    pulse_redirect(STALL_PC);  // predictor, trained while fetch is parked
    retire_branch(BRANCH_PC, 1'b1, TARGET_PC);
    retire_branch(BRANCH_PC, 1'b1, TARGET_PC);
    run_loop(TARGET_PC);
    pulse_redirect(STALL_PC);
    retire_branch(BRANCH_PC, 1'b0, TARGET_PC);
    run_loop(TARGET_PC);  // strong to weak taken, still predicted
    pulse_redirect(STALL_PC);
    retire_branch(BRANCH_PC, 1'b0, TARGET_PC);
    run_loop(BRANCH_PC + 64'd4);
    pulse_redirect(TAIL_PC);  // run off the end of memory
    wait_transfers(N_TAIL);
    set_ready(1);
    parked = transfers;
    repeat (20) @(negedge clock);
    compare_flag("dispatch_valid while parked", dispatch_valid, 1'b0);
    if (transfers != parked) fail_run("fetch delivered instructions past the end of memory");
    pulse_redirect(64'h8);
    wait_transfers(N_BACK);
    $display("sim passed");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+bench
rtl/fetch_pkg.sv
rtl/imem.sv
rtl/branch_predictor.sv
rtl/if_stage.sv
rtl/fetch_buffer.sv
rtl/fetch_top.sv
bench/fetch_tb.sv
